//--- sa_engine.f
+incdir+rtl
rtl/sa_pkg.sv
rtl/sa_pe.sv
rtl/sa_array.sv
rtl/sa_loader.sv
rtl/sa_deskew.sv
rtl/sa_engine.sv
test/tb_sa_engine.sv

//--- Bender.yml
package:
  name: sa_engine

export_include_dirs:
  - rtl

sources:
  - rtl/sa_pkg.sv
  - rtl/sa_pe.sv
  - rtl/sa_array.sv
  - rtl/sa_loader.sv
  - rtl/sa_deskew.sv
  - rtl/sa_engine.sv
  - target: test
    files:
      - test/tb_sa_engine.sv

//--- test/tb_sa_engine.sv
`include "sa_macros.svh"

module tb_sa_engine;

    localparam int N         = `SA_PE_SIZE;
    localparam int NUM_CASES = 5;
    localparam int MAX_VEC   = 2 * N + 4;
    localparam int TIMEOUT   = 4 * N + 8;

    logic              clk = 1'b0;
    logic              rst_n;
    logic              preload_i;
    sa_pkg::data_vec_t ifmap_i;
    logic              weight_valid_i;
    sa_pkg::data_vec_t weight_i;
    logic              result_valid_o;
    sa_pkg::psum_vec_t result_o;

    integer seed = 32'hfb93_3ff6;
    int     cycle = 0;

    // stimulus table, one entry per case
    string             case_name  [NUM_CASES];
    sa_pkg::data_vec_t case_ifmap [NUM_CASES][N];
    sa_pkg::data_vec_t case_wt    [NUM_CASES][MAX_VEC];
    int                case_gap   [NUM_CASES][MAX_VEC];
    int                case_nvec  [NUM_CASES];

    // expected results in issue order
    sa_pkg::psum_vec_t exp_vec_q  [$];
    int                exp_cyc_q  [$];
    string             exp_name_q [$];

    sa_engine u_sa_engine (
        .clk            (clk),
        .rst_n          (rst_n),
        .preload_i      (preload_i),
        .ifmap_i        (ifmap_i),
        .weight_valid_i (weight_valid_i),
        .weight_i       (weight_i),
        .result_valid_o (result_valid_o),
        .result_o       (result_o)
    );

    initial begin
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    task automatic abort_run();
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_bit(string name, logic expected, logic actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s expected %0b actual %0b", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_psum_vec(string name, sa_pkg::psum_vec_t expected,
                                  sa_pkg::psum_vec_t actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    // c-th element is the signed dot product of ifmap column c and the weights
    function automatic sa_pkg::psum_vec_t expected_result(int idx, sa_pkg::data_vec_t w);
        sa_pkg::psum_vec_t res;
        longint            acc;
        for (int c = 0; c < N; c++) begin
            acc = 0;
            for (int r = 0; r < N; r++) begin
                acc = acc + longint'($signed(case_ifmap[idx][r][c])) * longint'($signed(w[r]));
            end
            res[c] = sa_pkg::psum_t'(acc);
        end
        return res;
    endfunction

    task automatic build_table();
        case_name[0] = "single";
        case_name[1] = "back_to_back";
        case_name[2] = "signed_extremes";
        case_name[3] = "reload_random";
        case_name[4] = "irregular_gaps";
        case_nvec[0] = 1;
        case_nvec[1] = 2 * N + 2;
        case_nvec[2] = 4;
        case_nvec[3] = 6;
        case_nvec[4] = MAX_VEC;
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                case_ifmap[0][r][c] = sa_pkg::data_t'(r * N + c + 1);
                case_ifmap[1][r][c] = sa_pkg::data_t'(7 * r - 4 * c + 1);
                case_ifmap[2][r][c] = ((r + c) % 2) ? 8'sd127 : -8'sd128;
                case_ifmap[3][r][c] = sa_pkg::data_t'($random(seed));
                case_ifmap[4][r][c] = sa_pkg::data_t'($random(seed));
            end
        end
        for (int v = 0; v < MAX_VEC; v++) begin
            for (int r = 0; r < N; r++) begin
                case_wt[0][v][r] = (r % 2) ? sa_pkg::data_t'(-(r + 1)) : sa_pkg::data_t'(r + 3);
                case_wt[1][v][r] = sa_pkg::data_t'(3 * v - 5 * r - 2);
                // all low, all high, then the two alternations
                case (v % 4)
                    0: case_wt[2][v][r] = -8'sd128;
                    1: case_wt[2][v][r] = 8'sd127;
                    2: case_wt[2][v][r] = (r % 2) ? 8'sd127 : -8'sd128;
                    default: case_wt[2][v][r] = (r % 2) ? -8'sd128 : 8'sd127;
                endcase
                case_wt[3][v][r] = sa_pkg::data_t'($random(seed));
                case_wt[4][v][r] = sa_pkg::data_t'($random(seed));
            end
            case_gap[0][v] = 0;
            case_gap[1][v] = 0;
            case_gap[2][v] = 0;
            case_gap[3][v] = 0;
            case_gap[4][v] = $unsigned($random(seed)) % 4;
        end
    endtask

    task automatic wait_drain(string name);
        int waited;
        waited = 0;
        while (exp_cyc_q.size() > 0 && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (exp_cyc_q.size() > 0) begin
            $display("no result arrived for %s within %0d cycles", name, TIMEOUT);
            abort_run();
        end
    endtask

    task automatic apply_case(int idx);
        // first vector presented ends up in the bottom row
        for (int k = 0; k < N; k++) begin
            @(negedge clk);
            preload_i = (k == 0);
            ifmap_i   = case_ifmap[idx][N-1-k];
        end
        for (int v = 0; v < case_nvec[idx]; v++) begin
            for (int g = 0; g < case_gap[idx][v]; g++) begin
                @(negedge clk);
                preload_i      = 1'b0;
                weight_valid_i = 1'b0;
            end
            @(negedge clk);
            preload_i      = 1'b0;
            weight_valid_i = 1'b1;
            weight_i       = case_wt[idx][v];
            // sampled at the next rising edge, result 2N edges later
            exp_vec_q.push_back(expected_result(idx, case_wt[idx][v]));
            exp_cyc_q.push_back(cycle + 1 + 2 * N);
            exp_name_q.push_back($sformatf("%s[%0d]", case_name[idx], v));
        end
        @(negedge clk);
        preload_i      = 1'b0;
        weight_valid_i = 1'b0;
        wait_drain(case_name[idx]);
    endtask

    // valid must be high exactly at each expected cycle and low otherwise
    always @(negedge clk) begin
        if (exp_cyc_q.size() > 0 && cycle == exp_cyc_q[0]) begin
            check_bit({exp_name_q[0], " valid"}, 1'b1, result_valid_o);
            check_psum_vec(exp_name_q[0], exp_vec_q[0], result_o);
            void'(exp_cyc_q.pop_front());
            void'(exp_vec_q.pop_front());
            void'(exp_name_q.pop_front());
        end else begin
            check_bit("no extra valid", 1'b0, result_valid_o);
        end
    end

    initial begin
        rst_n          = 1'b0;
        preload_i      = 1'b0;
        ifmap_i        = '0;
        weight_valid_i = 1'b0;
        weight_i       = '0;
        build_table();
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        // idle after reset
        repeat (10) begin
            @(negedge clk);
            check_bit("reset_idle", 1'b0, result_valid_o);
        end
        for (int i = 0; i < NUM_CASES; i++) begin
            apply_case(i);
        end
        repeat (4) @(negedge clk);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- rtl/sa_engine.sv
`include "sa_macros.svh"

module sa_engine (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               preload_i,
    input  sa_pkg::data_vec_t  ifmap_i,
    input  logic               weight_valid_i,
    input  sa_pkg::data_vec_t  weight_i,
    output logic               result_valid_o,
    output sa_pkg::psum_vec_t  result_o
);

    logic                   ifmap_en;
    sa_pkg::data_vec_t      ifmap_row;
    logic [`SA_PE_SIZE-1:0] weight_en;
    sa_pkg::data_vec_t      weight_row;
    sa_pkg::psum_vec_t      psum_col;
    logic [`SA_PE_SIZE-1:0] psum_en_col;

    // decode: preload window and row skew
    sa_loader u_loader (
        .clk            (clk),
        .rst_n          (rst_n),
        .preload_i      (preload_i),
        .ifmap_i        (ifmap_i),
        .weight_valid_i (weight_valid_i),
        .weight_i       (weight_i),
        .ifmap_en_o     (ifmap_en),
        .ifmap_row_o    (ifmap_row),
        .weight_en_o    (weight_en),
        .weight_row_o   (weight_row)
    );

    sa_array u_array (
        .clk           (clk),
        .rst_n         (rst_n),
        .ifmap_en_i    (ifmap_en),
        .ifmap_row_i   (ifmap_row),
        .weight_en_i   (weight_en),
        .weight_row_i  (weight_row),
        .psum_col_o    (psum_col),
        .psum_en_col_o (psum_en_col)
    );

    // result: undo the column skew
    sa_deskew u_deskew (
        .clk            (clk),
        .rst_n          (rst_n),
        .psum_col_i     (psum_col),
        .psum_en_col_i  (psum_en_col),
        .result_valid_o (result_valid_o),
        .result_o       (result_o)
    );

endmodule

//--- rtl/sa_deskew.sv
`include "sa_macros.svh"

module sa_deskew (
    input  logic                    clk,
    input  logic                    rst_n,
    input  sa_pkg::psum_vec_t       psum_col_i,
    input  logic [`SA_PE_SIZE-1:0]  psum_en_col_i,
    output logic                    result_valid_o,
    output sa_pkg::psum_vec_t       result_o
);

    localparam int N = `SA_PE_SIZE;

    logic [N-1:0]      en_aligned;
    sa_pkg::psum_vec_t data_aligned;
    logic              valid_q;
    sa_pkg::psum_vec_t result_q;

    // column c is c cycles late, pad it with N-1-c stages
    for (genvar c = 0; c < N; c++) begin : g_col
        localparam int DEPTH = N - 1 - c;

        if (DEPTH == 0) begin : g_direct
            assign en_aligned[c]   = psum_en_col_i[c];
            assign data_aligned[c] = psum_col_i[c];
        end else begin : g_delay
            logic [DEPTH-1:0] en_q;
            sa_pkg::psum_t    data_q [0:DEPTH-1];

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    en_q <= '0;
                end else begin
                    en_q[0] <= psum_en_col_i[c];
                    for (int s = 1; s < DEPTH; s++) begin
                        en_q[s] <= en_q[s-1];
                    end
                end
            end

            always_ff @(posedge clk) begin
                data_q[0] <= psum_col_i[c];
                for (int s = 1; s < DEPTH; s++) begin
                    data_q[s] <= data_q[s-1];
                end
            end

            assign en_aligned[c]   = en_q[DEPTH-1];
            assign data_aligned[c] = data_q[DEPTH-1];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= en_aligned[0];
        end
    end

    // holds the last vector between results
    always_ff @(posedge clk) begin
        if (en_aligned[0]) begin
            result_q <= data_aligned;
        end
    end

    assign result_valid_o = valid_q;
    assign result_o       = result_q;

    // skew in the array and the padding here must cancel exactly
    a_columns_aligned: assert property (
        @(posedge clk) disable iff (!rst_n) (en_aligned == '0) || (&en_aligned)
    );

endmodule

//--- rtl/sa_loader.sv
`include "sa_macros.svh"

module sa_loader (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    preload_i,
    input  sa_pkg::data_vec_t       ifmap_i,
    input  logic                    weight_valid_i,
    input  sa_pkg::data_vec_t       weight_i,
    output logic                    ifmap_en_o,
    output sa_pkg::data_vec_t       ifmap_row_o,
    output logic [`SA_PE_SIZE-1:0]  weight_en_o,
    output sa_pkg::data_vec_t       weight_row_o
);

    localparam int N     = `SA_PE_SIZE;
    localparam int CNT_W = $clog2(N);

    sa_pkg::load_state_e state_q;
    logic [CNT_W-1:0]    cnt_q;

    // strobe cycle plus N-1 busy cycles
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= sa_pkg::LOAD_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                sa_pkg::LOAD_IDLE: begin
                    if (preload_i) begin
                        state_q <= sa_pkg::LOAD_BUSY;
                        cnt_q   <= CNT_W'(N - 2);
                    end
                end
                sa_pkg::LOAD_BUSY: begin
                    if (cnt_q == '0) begin
                        state_q <= sa_pkg::LOAD_IDLE;
                    end else begin
                        cnt_q <= cnt_q - 1'b1;
                    end
                end
                default: state_q <= sa_pkg::LOAD_IDLE;
            endcase
        end
    end

    assign ifmap_en_o  = preload_i || (state_q == sa_pkg::LOAD_BUSY);
    assign ifmap_row_o = ifmap_i;

    // row r delayed by 1+r cycles
    for (genvar r = 0; r < N; r++) begin : g_skew
        logic [r:0]    en_q;
        sa_pkg::data_t data_q [0:r];

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                en_q <= '0;
            end else begin
                en_q[0] <= weight_valid_i;
                for (int s = 1; s <= r; s++) begin
                    en_q[s] <= en_q[s-1];
                end
            end
        end

        always_ff @(posedge clk) begin
            data_q[0] <= weight_i[r];
            for (int s = 1; s <= r; s++) begin
                data_q[s] <= data_q[s-1];
            end
        end

        assign weight_en_o[r]  = en_q[r];
        assign weight_row_o[r] = data_q[r];
    end

    // host must keep weights out of the preload window
    a_no_weight_in_preload: assert property (
        @(posedge clk) disable iff (!rst_n) !(weight_valid_i && ifmap_en_o)
    );

    a_no_restart_while_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(preload_i && (state_q == sa_pkg::LOAD_BUSY))
    );

endmodule

//--- rtl/sa_array.sv
`include "sa_macros.svh"

module sa_array (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    ifmap_en_i,
    input  sa_pkg::data_vec_t       ifmap_row_i,
    input  logic [`SA_PE_SIZE-1:0]  weight_en_i,
    input  sa_pkg::data_vec_t       weight_row_i,
    output sa_pkg::psum_vec_t       psum_col_o,
    output logic [`SA_PE_SIZE-1:0]  psum_en_col_o
);

    localparam int N = `SA_PE_SIZE;

    // vertical chains, index [row][col], row N is the bottom edge
    sa_pkg::data_t ifmap_w   [0:N][0:N-1];
    sa_pkg::psum_t psum_w    [0:N][0:N-1];
    logic          psum_en_w [1:N][0:N-1];

    // horizontal chains, index [row][col], col N is the right edge
    sa_pkg::data_t weight_w    [0:N-1][0:N];
    logic          weight_en_w [0:N-1][0:N];

    for (genvar c = 0; c < N; c++) begin : g_top
        assign ifmap_w[0][c] = ifmap_row_i[c];
        // no external psum input, top of each column starts at zero
        assign psum_w[0][c]  = '0;
    end

    // weights enter from the left, already skewed per row
    for (genvar r = 0; r < N; r++) begin : g_left
        assign weight_w[r][0]    = weight_row_i[r];
        assign weight_en_w[r][0] = weight_en_i[r];
    end

    for (genvar r = 0; r < N; r++) begin : g_row
        for (genvar c = 0; c < N; c++) begin : g_col
            sa_pe u_pe (
                .clk         (clk),
                .rst_n       (rst_n),
                .ifmap_en_i  (ifmap_en_i),
                .ifmap_i     (ifmap_w[r][c]),
                .weight_en_i (weight_en_w[r][c]),
                .weight_i    (weight_w[r][c]),
                .psum_i      (psum_w[r][c]),
                .ifmap_o     (ifmap_w[r+1][c]),
                .weight_en_o (weight_en_w[r][c+1]),
                .weight_o    (weight_w[r][c+1]),
                .psum_en_o   (psum_en_w[r+1][c]),
                .psum_o      (psum_w[r+1][c])
            );
        end
    end

    // only the bottom row leaves the array
    for (genvar c = 0; c < N; c++) begin : g_bottom
        assign psum_col_o[c]    = psum_w[N][c];
        assign psum_en_col_o[c] = psum_en_w[N][c];
    end

endmodule

//--- rtl/sa_pe.sv
module sa_pe (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          ifmap_en_i,
    input  sa_pkg::data_t ifmap_i,
    input  logic          weight_en_i,
    input  sa_pkg::data_t weight_i,
    input  sa_pkg::psum_t psum_i,
    output sa_pkg::data_t ifmap_o,
    output logic          weight_en_o,
    output sa_pkg::data_t weight_o,
    output logic          psum_en_o,
    output sa_pkg::psum_t psum_o
);

    sa_pkg::data_t ifmap_q;
    sa_pkg::data_t weight_q;
    sa_pkg::psum_t psum_q;
    logic          en_q;
    logic signed [2*$bits(sa_pkg::data_t)-1:0] prod;

    // stationary operand, shifted in from the row above
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ifmap_q <= '0;
        end else if (ifmap_en_i) begin
            ifmap_q <= ifmap_i;
        end
    end

    // full precision product, both operands signed
    assign prod = ifmap_q * weight_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            en_q <= 1'b0;
        end else begin
            en_q <= weight_en_i;
        end
    end

    // weight goes right, psum goes down
    always_ff @(posedge clk) begin
        if (weight_en_i) begin
            weight_q <= weight_i;
            psum_q   <= psum_i + sa_pkg::psum_t'(prod);
        end
    end

    assign ifmap_o     = ifmap_q;
    assign weight_o    = weight_q;
    assign weight_en_o = en_q;
    assign psum_o      = psum_q;
    assign psum_en_o   = en_q;

    // preload and streaming must never overlap in a cell
    a_no_load_during_mac: assert property (
        @(posedge clk) disable iff (!rst_n) !(ifmap_en_i && weight_en_i)
    );

endmodule

//--- rtl/sa_pkg.sv
package sa_pkg;

    `include "sa_macros.svh"

    // single signed ifmap or weight element
    typedef logic signed [`SA_DATA_WIDTH-1:0] data_t;

    // single signed partial or final sum
    typedef logic signed [`SA_PSUM_WIDTH-1:0] psum_t;

    // element 0 sits in the low bits
    typedef data_t [`SA_PE_SIZE-1:0] data_vec_t;

    // one sum per column, element 0 low
    typedef psum_t [`SA_PE_SIZE-1:0] psum_vec_t;

    // preload window tracking
    typedef enum logic {
        LOAD_IDLE,
        LOAD_BUSY
    } load_state_e;

endpackage

//--- rtl/sa_macros.svh
`ifndef SA_MACROS_SVH
`define SA_MACROS_SVH

// rows and columns of the square array
`define SA_PE_SIZE 2

// ifmap and weight element width
`define SA_DATA_WIDTH 8

// accumulated sum width
`define SA_PSUM_WIDTH 32

`endif
